// ==== hw/mvdmPkg.sv ====
// geometry is fixed at two 128x128 8-bit images and one 8x8 block; the fraction bit is ignored
package mvdmPkg;

    // ====================
    // image geometry
    // ====================
    localparam int IMG_DIM    = 128;
    localparam int COORD_W    = 7;
    localparam int PIX_W      = 8;
    localparam int IMG_PIXELS = IMG_DIM * IMG_DIM;
    // row in the upper bits, column in the lower bits
    localparam int IMG_ADDR_W = 14;
    // top bit picks L0 or L1
    localparam int LOAD_W     = 15;

    localparam logic [COORD_W-1:0] COORD_MAX = COORD_W'(IMG_DIM - 1);

    // ====================
    // block and result
    // ====================
    localparam int BLK_DIM   = 8;
    localparam int BLK_IDX_W = 3;
    localparam int BLK_CNT_W = 2 * BLK_IDX_W;
    // 64 differences of at most 255 fit in 14 bits
    localparam int SAD_W     = 14;
    localparam int BIT_CNT_W = $clog2(SAD_W + 1);

    localparam logic [BLK_CNT_W-1:0] BLK_LAST = BLK_CNT_W'(BLK_DIM * BLK_DIM - 1);

    // ====================
    // input protocol
    // ====================
    localparam int NUM_MV_WORDS = 4;
    localparam int MV_CNT_W     = $clog2(NUM_MV_WORDS);
    localparam int IN_W         = 9;

    localparam logic [MV_CNT_W-1:0] MV_LAST = MV_CNT_W'(NUM_MV_WORDS - 1);

    // controller state encoding
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE = 2'd0;
    localparam logic [STATE_W-1:0] ST_LOAD = 2'd1;
    localparam logic [STATE_W-1:0] ST_MV   = 2'd2;
    localparam logic [STATE_W-1:0] ST_READ = 2'd3;

    // same 9-bit word seen as a pixel during load, as a vector word during entry
    typedef union packed {
        struct packed {
            logic [PIX_W-1:0] pix;
            logic             pad;
        } pixel;
        struct packed {
            logic               pad;
            logic [COORD_W-1:0] coord;
            logic               frac;
        } vector;
    } inWord_u;

endpackage

// ==== hw/mvdmCtrl.sv ====
// in_valid must last exactly two images; a new vector burst only after out_valid has fallen
`timescale 1ns/10ps

module mvdmCtrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_valid,
    input  logic                           in_valid2,
    input  mvdmPkg::inWord_u               in_data,
    output logic                           wrEnL0,
    output logic                           wrEnL1,
    output logic [mvdmPkg::IMG_ADDR_W-1:0] wrAddr,
    output logic [mvdmPkg::PIX_W-1:0]      wrPix,
    output logic [mvdmPkg::COORD_W-1:0]    originXL0,
    output logic [mvdmPkg::COORD_W-1:0]    originYL0,
    output logic [mvdmPkg::COORD_W-1:0]    originXL1,
    output logic [mvdmPkg::COORD_W-1:0]    originYL1,
    output logic                           rdEn,
    output logic                           rdLast,
    output logic [mvdmPkg::BLK_IDX_W-1:0]  blkRow,
    output logic [mvdmPkg::BLK_IDX_W-1:0]  blkCol
);

    logic [mvdmPkg::STATE_W-1:0]   state;
    logic [mvdmPkg::STATE_W-1:0]   nextState;
    logic [mvdmPkg::LOAD_W-1:0]    loadCnt;
    logic [mvdmPkg::MV_CNT_W-1:0]  mvCnt;
    logic [mvdmPkg::BLK_CNT_W-1:0] blkIdx;
    logic [mvdmPkg::COORD_W-1:0]   mvCoord [mvdmPkg::NUM_MV_WORDS];
    logic                          loadTake;
    logic                          mvTake;
    logic                          lastMvWord;
    logic                          lastBlkStep;

    // inputs are only accepted outside the read phase
    assign loadTake = in_valid &&
                      (state == mvdmPkg::ST_IDLE || state == mvdmPkg::ST_LOAD);
    assign mvTake   = in_valid2 &&
                      (state == mvdmPkg::ST_IDLE || state == mvdmPkg::ST_MV);

    assign lastMvWord  = mvTake && (mvCnt == mvdmPkg::MV_LAST);
    assign lastBlkStep = (state == mvdmPkg::ST_READ) && (blkIdx == mvdmPkg::BLK_LAST);

    // ====================
    // phase FSM
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mvdmPkg::ST_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            mvdmPkg::ST_IDLE: begin
                if (in_valid) begin
                    nextState = mvdmPkg::ST_LOAD;
                end else if (in_valid2) begin
                    nextState = mvdmPkg::ST_MV;
                end
            end
            mvdmPkg::ST_LOAD: begin
                // counter wraps to zero after the last L1 pixel
                if (!in_valid || (&loadCnt)) begin
                    nextState = mvdmPkg::ST_IDLE;
                end
            end
            mvdmPkg::ST_MV: begin
                if (lastMvWord) begin
                    nextState = mvdmPkg::ST_READ;
                end else if (!in_valid2) begin
                    nextState = mvdmPkg::ST_IDLE;
                end
            end
            default: begin
                if (lastBlkStep) begin
                    nextState = mvdmPkg::ST_IDLE;
                end
            end
        endcase
    end

    // ====================
    // image load
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loadCnt <= '0;
        end else if (loadTake) begin
            loadCnt <= loadCnt + 1'b1;
        end else begin
            loadCnt <= '0;
        end
    end

    // write lands on the edge that ends the in_valid cycle
    assign wrEnL0 = loadTake && !loadCnt[mvdmPkg::LOAD_W-1];
    assign wrEnL1 = loadTake && loadCnt[mvdmPkg::LOAD_W-1];
    assign wrAddr = loadCnt[mvdmPkg::IMG_ADDR_W-1:0];
    assign wrPix  = in_data.pixel.pix;

    // ====================
    // vector capture
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mvCnt <= '0;
        end else if (mvTake) begin
            mvCnt <= mvCnt + 1'b1;
        end else begin
            mvCnt <= '0;
        end
    end

    // word order L0 x, L0 y, L1 x, L1 y; fraction bit dropped
    always_ff @(posedge clk) begin
        if (mvTake) begin
            mvCoord[mvCnt] <= in_data.vector.coord;
        end
    end

    assign originXL0 = mvCoord[0];
    assign originYL0 = mvCoord[1];
    assign originXL1 = mvCoord[2];
    assign originYL1 = mvCoord[3];

    // ====================
    // block read sequence
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blkIdx <= '0;
        end else if (state == mvdmPkg::ST_READ) begin
            blkIdx <= blkIdx + 1'b1;
        end else begin
            blkIdx <= '0;
        end
    end

    // row-major walk over the 8x8 block
    assign rdEn   = (state == mvdmPkg::ST_READ);
    assign rdLast = lastBlkStep;
    assign blkRow = blkIdx[mvdmPkg::BLK_CNT_W-1:mvdmPkg::BLK_IDX_W];
    assign blkCol = blkIdx[mvdmPkg::BLK_IDX_W-1:0];

endmodule

// ==== hw/blockFetch.sv ====
// behavioral single-image memory; reads past the right or bottom edge repeat pixel 127
`timescale 1ns/10ps

module blockFetch (
    input  logic                           clk,
    input  logic                           wrEn,
    input  logic [mvdmPkg::IMG_ADDR_W-1:0] wrAddr,
    input  logic [mvdmPkg::PIX_W-1:0]      wrPix,
    input  logic [mvdmPkg::COORD_W-1:0]    originX,
    input  logic [mvdmPkg::COORD_W-1:0]    originY,
    input  logic                           rdEn,
    input  logic [mvdmPkg::BLK_IDX_W-1:0]  blkRow,
    input  logic [mvdmPkg::BLK_IDX_W-1:0]  blkCol,
    output logic [mvdmPkg::PIX_W-1:0]      pix
);

    logic [mvdmPkg::PIX_W-1:0]      imgMem [mvdmPkg::IMG_PIXELS];
    logic [mvdmPkg::COORD_W-1:0]    rdX;
    logic [mvdmPkg::COORD_W-1:0]    rdY;
    logic [mvdmPkg::IMG_ADDR_W-1:0] rdAddr;

    // origin plus offset, saturated at the last row or column
    function automatic logic [mvdmPkg::COORD_W-1:0] clampAxis(
        input logic [mvdmPkg::COORD_W-1:0]   origin,
        input logic [mvdmPkg::BLK_IDX_W-1:0] offset
    );
        logic [mvdmPkg::COORD_W:0] sum;
        sum = {1'b0, origin} +
              {{(mvdmPkg::COORD_W + 1 - mvdmPkg::BLK_IDX_W){1'b0}}, offset};
        if (sum > {1'b0, mvdmPkg::COORD_MAX}) begin
            return mvdmPkg::COORD_MAX;
        end
        return sum[mvdmPkg::COORD_W-1:0];
    endfunction

    // ====================
    // load port
    // ====================
    always_ff @(posedge clk) begin
        if (wrEn) begin
            imgMem[wrAddr] <= wrPix;
        end
    end

    // ====================
    // block read
    // ====================
    assign rdX    = clampAxis(originX, blkCol);
    assign rdY    = clampAxis(originY, blkRow);
    assign rdAddr = {rdY, rdX};

    // one cycle from rdEn to pix
    always_ff @(posedge clk) begin
        if (rdEn) begin
            pix <= imgMem[rdAddr];
        end
    end

endmodule

// ==== hw/sadAccum.sv ====
// expects one 64-pixel burst per request and no new burst while the result is still shifting
`timescale 1ns/10ps

module sadAccum (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [mvdmPkg::PIX_W-1:0] pixL0,
    input  logic [mvdmPkg::PIX_W-1:0] pixL1,
    input  logic                      rdEn,
    input  logic                      rdLast,
    output logic                      out_valid,
    output logic                      out_sad
);

    logic                          pixValid;
    logic                          pixFirst;
    logic                          pixLast;
    logic                          sumReady;
    logic [mvdmPkg::PIX_W-1:0]     absDiff;
    logic [mvdmPkg::SAD_W-1:0]     sum;
    logic [mvdmPkg::SAD_W-1:0]     shiftReg;
    logic [mvdmPkg::BIT_CNT_W-1:0] bitCnt;

    // ====================
    // read latency align
    // ====================
    // pixValid is rdEn of the previous cycle, so rdEn && !pixValid is the rising edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixValid <= 1'b0;
            pixFirst <= 1'b0;
            pixLast  <= 1'b0;
            sumReady <= 1'b0;
        end else begin
            pixValid <= rdEn;
            pixFirst <= rdEn && !pixValid;
            pixLast  <= rdLast;
            sumReady <= pixLast;
        end
    end

    // ====================
    // accumulate
    // ====================
    assign absDiff = (pixL0 > pixL1) ? (pixL0 - pixL1) : (pixL1 - pixL0);

    always_ff @(posedge clk) begin
        if (pixValid) begin
            sum <= (pixFirst ? '0 : sum) +
                   {{(mvdmPkg::SAD_W - mvdmPkg::PIX_W){1'b0}}, absDiff};
        end
    end

    // ====================
    // serial output
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bitCnt <= '0;
        end else if (sumReady) begin
            bitCnt <= mvdmPkg::BIT_CNT_W'(mvdmPkg::SAD_W);
        end else if (bitCnt != '0) begin
            bitCnt <= bitCnt - 1'b1;
        end
    end

    // msb first
    always_ff @(posedge clk) begin
        if (sumReady) begin
            shiftReg <= sum;
        end else if (bitCnt != '0) begin
            shiftReg <= {shiftReg[mvdmPkg::SAD_W-2:0], 1'b0};
        end
    end

    assign out_valid = (bitCnt != '0);
    assign out_sad   = out_valid && shiftReg[mvdmPkg::SAD_W-1];

endmodule

// ==== hw/mvdmTop.sv ====
// SAD of two 8x8 integer-pel blocks; images persist across requests, no back-pressure
`timescale 1ns/10ps

module mvdmTop (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic                     in_valid2,
    input  logic [mvdmPkg::IN_W-1:0] in_data,
    output logic                     out_valid,
    output logic                     out_sad
);

    logic                           wrEnL0;
    logic                           wrEnL1;
    logic [mvdmPkg::IMG_ADDR_W-1:0] wrAddr;
    logic [mvdmPkg::PIX_W-1:0]      wrPix;
    logic [mvdmPkg::COORD_W-1:0]    originXL0;
    logic [mvdmPkg::COORD_W-1:0]    originYL0;
    logic [mvdmPkg::COORD_W-1:0]    originXL1;
    logic [mvdmPkg::COORD_W-1:0]    originYL1;
    logic                           rdEn;
    logic                           rdLast;
    logic [mvdmPkg::BLK_IDX_W-1:0]  blkRow;
    logic [mvdmPkg::BLK_IDX_W-1:0]  blkCol;
    logic [mvdmPkg::PIX_W-1:0]      pixL0;
    logic [mvdmPkg::PIX_W-1:0]      pixL1;

    mvdmCtrl uCtrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .in_data   (in_data),
        .wrEnL0    (wrEnL0),
        .wrEnL1    (wrEnL1),
        .wrAddr    (wrAddr),
        .wrPix     (wrPix),
        .originXL0 (originXL0),
        .originYL0 (originYL0),
        .originXL1 (originXL1),
        .originYL1 (originYL1),
        .rdEn      (rdEn),
        .rdLast    (rdLast),
        .blkRow    (blkRow),
        .blkCol    (blkCol)
    );

    // both fetchers read the same block position in lockstep
    blockFetch uFetchL0 (
        .clk     (clk),
        .wrEn    (wrEnL0),
        .wrAddr  (wrAddr),
        .wrPix   (wrPix),
        .originX (originXL0),
        .originY (originYL0),
        .rdEn    (rdEn),
        .blkRow  (blkRow),
        .blkCol  (blkCol),
        .pix     (pixL0)
    );

    blockFetch uFetchL1 (
        .clk     (clk),
        .wrEn    (wrEnL1),
        .wrAddr  (wrAddr),
        .wrPix   (wrPix),
        .originX (originXL1),
        .originY (originYL1),
        .rdEn    (rdEn),
        .blkRow  (blkRow),
        .blkCol  (blkCol),
        .pix     (pixL1)
    );

    sadAccum uSad (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixL0     (pixL0),
        .pixL1     (pixL1),
        .rdEn      (rdEn),
        .rdLast    (rdLast),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

endmodule

// ==== tests/mvdmProps_sva.sv ====
// output frame checks only; the 14-cycle limit assumes one frame per request with a gap after it
`timescale 1ns/10ps

module mvdmProps (
    input logic clk,
    input logic rst_n,
    input logic in_valid,
    input logic in_valid2,
    input logic out_valid,
    input logic out_sad
);

    // cycles out_valid has already been high in the current frame
    logic [mvdmPkg::BIT_CNT_W:0] highRun;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            highRun <= '0;
        end else if (out_valid) begin
            highRun <= highRun + 1'b1;
        end else begin
            highRun <= '0;
        end
    end

    quietSad: assert property (@(posedge clk) disable iff (!rst_n) !out_valid |-> !out_sad)
        else $error("out_sad high while out_valid is low");

    frameLimit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (highRun < (mvdmPkg::BIT_CNT_W + 1)'(mvdmPkg::SAD_W)))
        else $error("out_valid high for more than SAD_W cycles");

    phaseOverlap: assert property (@(posedge clk) disable iff (!rst_n) !(in_valid && in_valid2))
        else $error("in_valid and in_valid2 high together");

    resetQuiet: assert property (@(posedge clk) !rst_n |-> (!out_valid && !out_sad))
        else $error("outputs active during reset");

endmodule

bind mvdmTop mvdmProps uProps (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_valid2 (in_valid2),
    .out_valid (out_valid),
    .out_sad   (out_sad)
);

// ==== tests/mvdmTb.sv ====
// loads both images twice and checks integer-pel SAD results; needs a simulator with timing support
`timescale 1ns/10ps

module mvdmTb;

    localparam int NUM_LOADS = 2;
    localparam int NUM_REQS  = 21;
    localparam int WDOG_CYC  = NUM_LOADS * 2 * mvdmPkg::IMG_PIXELS + 400 * NUM_REQS;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       in_valid;
    logic                       in_valid2;
    logic [mvdmPkg::IN_W-1:0]   in_data;
    logic                       out_valid;
    logic                       out_sad;

    logic [mvdmPkg::PIX_W-1:0]  imgL0 [mvdmPkg::IMG_PIXELS];
    logic [mvdmPkg::PIX_W-1:0]  imgL1 [mvdmPkg::IMG_PIXELS];
    logic [mvdmPkg::SAD_W-1:0]  rxWord;
    int                         rxCnt;
    int                         expQ[$];
    string                      nameQ[$];
    int                         gotQ[$];
    int                         reqCnt;
    int                         doneCnt;
    event                       frameDone;

    mvdmTop u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_valid2 (in_valid2),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_sad   (out_sad)
    );

    always #4 clk = ~clk;

    // ====================
    // reference model
    // ====================
    // block pixels past the last row or column repeat that row or column
    function automatic int refSad(input int x0, input int y0, input int x1, input int y1);
        int sad;
        int xa;
        int ya;
        int xb;
        int yb;
        int pa;
        int pb;
        sad = 0;
        for (int r = 0; r < 8; r++) begin
            for (int c = 0; c < 8; c++) begin
                xa = (x0 + c > 127) ? 127 : x0 + c;
                ya = (y0 + r > 127) ? 127 : y0 + r;
                xb = (x1 + c > 127) ? 127 : x1 + c;
                yb = (y1 + r > 127) ? 127 : y1 + r;
                pa = int'(imgL0[ya * 128 + xa]);
                pb = int'(imgL1[yb * 128 + xb]);
                sad += (pa > pb) ? pa - pb : pb - pa;
            end
        end
        return sad;
    endfunction

    task automatic checkVal(input string name, input int expVal, input int gotVal);
        if (expVal != gotVal) begin
            $display("ERR %s expected %0d actual %0d", name, expVal, gotVal);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // ====================
    // stimulus tasks
    // ====================
    task automatic loadImages(input bit sameImg);
        for (int i = 0; i < mvdmPkg::IMG_PIXELS; i++) begin
            imgL0[i] = 8'($urandom);
            imgL1[i] = sameImg ? imgL0[i] : 8'($urandom);
        end
        // all of L0 then all of L1, row-major
        for (int i = 0; i < 2 * mvdmPkg::IMG_PIXELS; i++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_data  = {(i < mvdmPkg::IMG_PIXELS) ? imgL0[i] : imgL1[i - mvdmPkg::IMG_PIXELS],
                        1'b0};
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic sendRequest(input string name, input int x0, input int y0, input int x1,
                               input int y1, input bit frac, input int expVal);
        int w [4];
        w[0] = x0;
        w[1] = y0;
        w[2] = x1;
        w[3] = y1;
        expQ.push_back(expVal);
        nameQ.push_back(name);
        reqCnt++;
        for (int k = 0; k < mvdmPkg::NUM_MV_WORDS; k++) begin
            @(posedge clk);
            #1;
            in_valid2 = 1'b1;
            in_data   = {1'b0, 7'(w[k]), frac};
        end
        @(posedge clk);
        #1;
        in_valid2 = 1'b0;
        in_data   = '0;
        // next burst only once the frame has ended
        wait (doneCnt == reqCnt);
        repeat (3) @(posedge clk);
    endtask

    // ====================
    // receive and compare
    // ====================
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid) begin
                if (expQ.size() == 0) begin
                    $display("out_valid went high while no request was pending");
                    $display("*** TEST FAILED ***");
                    $fatal(1, "unexpected output frame");
                end else begin
                    rxWord = {rxWord[mvdmPkg::SAD_W-2:0], out_sad};
                    rxCnt++;
                end
            end else if (rxCnt != 0) begin
                checkVal("frame length", mvdmPkg::SAD_W, rxCnt);
                gotQ.push_back(int'(rxWord));
                rxCnt = 0;
                -> frameDone;
            end
        end
    end

    initial begin
        forever begin
            @(frameDone);
            while (gotQ.size() != 0) begin
                checkVal(nameQ.pop_front(), expQ.pop_front(), gotQ.pop_front());
                doneCnt++;
            end
        end
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run timed out", WDOG_CYC);
        $display("*** TEST FAILED ***");
        $fatal(1, "timeout");
    end

    // ====================
    // main sequence
    // ====================
    initial begin
        int x0;
        int y0;
        int x1;
        int y1;
        void'($urandom(32'hd300d991));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_valid2 = 1'b0;
        in_data   = '0;
        rxWord    = '0;
        rxCnt     = 0;
        reqCnt    = 0;
        doneCnt   = 0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // outputs quiet before any request
        repeat (20) begin
            @(negedge clk);
            checkVal("idle after reset", 0, int'({out_valid, out_sad}));
        end

        loadImages(1'b0);
        repeat (8) begin
            x0 = $urandom_range(120);
            y0 = $urandom_range(120);
            x1 = $urandom_range(120);
            y1 = $urandom_range(120);
            sendRequest("random interior", x0, y0, x1, y1, 1'b0, refSad(x0, y0, x1, y1));
        end

        sendRequest("clamp corner", 127, 127, 0, 0, 1'b0, refSad(127, 127, 0, 0));
        sendRequest("clamp x", 124, 50, 127, 3, 1'b0, refSad(124, 50, 127, 3));
        sendRequest("clamp y", 60, 125, 120, 127, 1'b0, refSad(60, 125, 120, 127));
        sendRequest("clamp mixed", 127, 0, 0, 127, 1'b0, refSad(127, 0, 0, 127));

        // fraction bit must not change the result
        sendRequest("frac clear", 33, 77, 90, 12, 1'b0, refSad(33, 77, 90, 12));
        sendRequest("frac set", 33, 77, 90, 12, 1'b1, refSad(33, 77, 90, 12));

        // images still hold the first load
        repeat (4) begin
            x0 = $urandom_range(127);
            y0 = $urandom_range(127);
            x1 = $urandom_range(127);
            y1 = $urandom_range(127);
            sendRequest("persist", x0, y0, x1, y1, 1'b0, refSad(x0, y0, x1, y1));
        end

        loadImages(1'b1);
        sendRequest("same image", 10, 20, 10, 20, 1'b0, 0);
        sendRequest("same image edge", 126, 127, 126, 127, 1'b0, 0);
        sendRequest("same image frac", 64, 3, 64, 3, 1'b1, 0);

        if (doneCnt == NUM_REQS) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d of %0d requests completed", doneCnt, NUM_REQS);
            $display("*** TEST FAILED ***");
            $fatal(1, "run ended with missing results");
        end
    end

endmodule

// ==== sim.f ====
hw/mvdmPkg.sv
hw/mvdmCtrl.sv
hw/blockFetch.sv
hw/sadAccum.sv
hw/mvdmTop.sv
tests/mvdmProps_sva.sv
tests/mvdmTb.sv

// ==== Makefile ====
# Verilator flow for the motion-vector SAD engine
VERILATOR ?= verilator
TOP       ?= mvdmTb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulation binary is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
